/* mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Datapath width, used for words and byte addresses
`define MIPS_DATA_W 32

// Register file geometry
`define MIPS_REG_COUNT 32
`define MIPS_REG_ADDR_W 5

// First fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// Jumping here stops the CPU
`define MIPS_HALT_ADDR 32'h00000000

// Word accesses only, all four lanes on
`define MIPS_BYTEEN_ALL 4'b1111

`define MIPS_V0_INDEX 2    // $v0 is shown on register_v0

`endif

/* mips_core_pkg.sv */
`default_nettype none

`include "mips_macros.svh"

package mips_core_pkg;

    // Multicycle sequencer states
    typedef enum logic [1:0] {
        FETCH = 2'd0,    // Instruction read on the bus
        EXEC  = 2'd1,    // Decode, ALU, writeback or PC update
        MEM   = 2'd2,    // Data read or write for LW/SW
        HALT  = 2'd3     // Parked until reset
    } ctrl_state_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,    // Signed compare
        ALU_SLTU = 4'd6,    // Unsigned compare
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9,    // Keeps the sign bit
        ALU_LUI  = 4'd10    // Immediate into the upper half
    } alu_op_t;

    // Second ALU operand
    typedef enum logic {
        SRC_REG = 1'b0,    // rt read data
        SRC_IMM = 1'b1     // Extended immediate
    } alu_src_t;

    // One Avalon request, driven by the control unit
    typedef struct packed {
        logic [`MIPS_DATA_W-1:0] address;
        logic                    read;
        logic                    write;
        logic [`MIPS_DATA_W-1:0] writedata;
    } bus_req_t;

endpackage

`default_nettype wire

/* mips_isa_pkg.sv */
`default_nettype none

`include "mips_macros.svh"

package mips_isa_pkg;

    import mips_core_pkg::*;

    typedef logic [`MIPS_DATA_W-1:0]     word_t;      // Data word or byte address
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;  // Register index
    typedef logic [15:0]                 imm16_t;     // Raw I-type immediate
    typedef logic [25:0]                 jtarget_t;   // Raw J-type target
    typedef logic [4:0]                  shamt_t;     // Shift amount

    // Primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_R     = 6'd0,     // Function field selects the operation
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // R-type function codes, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_SLLV = 6'd4,
        FN_SRLV = 6'd6,
        FN_SRAV = 6'd7,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef struct packed {
        alu_op_t   alu_op;
        alu_src_t  src_b;
        logic      shift_var;   // Shift amount comes from rs
        logic      wr_en;       // Result goes to the register file
        reg_addr_t wr_addr;
        word_t     imm;         // Already extended
        shamt_t    shamt;       // Zero unless a fixed shift
        logic      is_load;
        logic      is_store;
        logic      is_beq;
        logic      is_bne;
        logic      is_j;
        logic      is_jr;
        reg_addr_t rs;
        reg_addr_t rt;
        jtarget_t  target;
    } decoded_instr_t;

endpackage

`default_nettype wire

/* mips_decoder.sv */
`default_nettype none

module mips_decoder
    import mips_core_pkg::*;
    import mips_isa_pkg::*;
(
    input  wire word_t      instr,
    output decoded_instr_t  dec
);

    opcode_t   opcode;
    funct_t    funct;
    imm16_t    imm16;
    reg_addr_t rd_field;
    shamt_t    sh_field;

    // Field split
    assign opcode   = opcode_t'(instr[31:26]);
    assign funct    = funct_t'(instr[5:0]);
    assign imm16    = instr[15:0];
    assign rd_field = instr[15:11];
    assign sh_field = instr[10:6];

    always_comb begin
        dec         = '0;                   // Unknown encodings fall out as no-ops
        dec.alu_op  = ALU_ADD;
        dec.src_b   = SRC_REG;
        dec.rs      = instr[25:21];
        dec.rt      = instr[20:16];
        dec.target  = instr[25:0];
        dec.imm     = {{16{imm16[15]}}, imm16};    // Sign extend by default
        dec.wr_addr = instr[20:16];                // rt for I-type

        case (opcode)
            OP_R: begin
                dec.wr_addr = rd_field;
                dec.wr_en   = 1'b1;
                case (funct)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLTU: dec.alu_op = ALU_SLTU;
                    FN_SLL: begin
                        dec.alu_op = ALU_SLL;
                        dec.shamt  = sh_field;
                    end
                    FN_SRL: begin
                        dec.alu_op = ALU_SRL;
                        dec.shamt  = sh_field;
                    end
                    FN_SRA: begin
                        dec.alu_op = ALU_SRA;
                        dec.shamt  = sh_field;
                    end
                    FN_SLLV: begin
                        dec.alu_op    = ALU_SLL;
                        dec.shift_var = 1'b1;
                    end
                    FN_SRLV: begin
                        dec.alu_op    = ALU_SRL;
                        dec.shift_var = 1'b1;
                    end
                    FN_SRAV: begin
                        dec.alu_op    = ALU_SRA;
                        dec.shift_var = 1'b1;
                    end
                    FN_JR: begin
                        dec.wr_en = 1'b0;    // No link register in this subset
                        dec.is_jr = 1'b1;
                    end
                    default: dec.wr_en = 1'b0;
                endcase
            end
            OP_J:   dec.is_j = 1'b1;
            OP_BEQ: dec.is_beq = 1'b1;     // Compare rs with rt through the ALU
            OP_BNE: dec.is_bne = 1'b1;
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LUI: begin
                dec.wr_en = 1'b1;
                dec.src_b = SRC_IMM;
                case (opcode)
                    OP_SLTI:  dec.alu_op = ALU_SLT;
                    OP_SLTIU: dec.alu_op = ALU_SLTU;    // Sign-extended, then unsigned compare
                    OP_LUI:   dec.alu_op = ALU_LUI;
                    default:  dec.alu_op = ALU_ADD;
                endcase
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                dec.wr_en = 1'b1;
                dec.src_b = SRC_IMM;
                dec.imm   = {16'b0, imm16};         // Logical immediates zero extend
                case (opcode)
                    OP_ANDI: dec.alu_op = ALU_AND;
                    OP_ORI:  dec.alu_op = ALU_OR;
                    default: dec.alu_op = ALU_XOR;
                endcase
            end
            OP_LW: begin
                dec.wr_en   = 1'b1;                 // Written from readdata in MEM
                dec.src_b   = SRC_IMM;
                dec.is_load = 1'b1;
            end
            OP_SW: begin
                dec.src_b    = SRC_IMM;
                dec.is_store = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* mips_alu.sv */
`default_nettype none

module mips_alu
    import mips_core_pkg::*;
    import mips_isa_pkg::*;
(
    input  wire alu_op_t op,
    input  wire word_t   a,
    input  wire word_t   b,
    input  wire shamt_t  shamt,
    output word_t        result,
    output logic         equal
);

    shamt_t sh;
    logic   lt_signed;
    logic   lt_unsigned;

    // Control zeroes a on fixed shifts and the decoder zeroes shamt on variable ones
    assign sh = shamt | a[4:0];

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    assign equal = (a == b);    // BEQ / BNE condition

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {{(`MIPS_DATA_W-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(`MIPS_DATA_W-1){1'b0}}, lt_unsigned};
            ALU_SLL:  result = b << sh;                 // Shifted value is rt
            ALU_SRL:  result = b >> sh;
            ALU_SRA:  result = word_t'($signed(b) >>> sh);
            ALU_LUI:  result = {b[15:0], 16'b0};
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* mips_reg_file.sv */
`default_nettype none

`include "mips_macros.svh"

module mips_reg_file
    import mips_isa_pkg::*;
(
    input  wire            clk,
    input  wire            reset,
    input  wire reg_addr_t rd_addr_a,
    input  wire reg_addr_t rd_addr_b,
    output word_t          rd_data_a,
    output word_t          rd_data_b,
    input  wire            wr_en,
    input  wire reg_addr_t wr_addr,
    input  wire word_t     wr_data,
    output word_t          v0
);

    word_t regs [0:`MIPS_REG_COUNT-1];

    // $zero is cleared here and never written afterwards
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];    // Combinational reads
    assign rd_data_b = regs[rd_addr_b];
    assign v0        = regs[`MIPS_V0_INDEX];

endmodule

`default_nettype wire

/* mips_control.sv */
`default_nettype none

`include "mips_macros.svh"

module mips_control
    import mips_core_pkg::*;
    import mips_isa_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire decoded_instr_t dec,
    input  wire word_t          rs_data,
    input  wire word_t          rt_data,
    input  wire word_t          alu_result,
    input  wire                 alu_equal,
    input  wire word_t          readdata,
    input  wire                 waitrequest,
    output word_t               instr,
    output word_t               alu_a,
    output word_t               alu_b,
    output logic                wr_en,
    output reg_addr_t           wr_addr,
    output word_t               wr_data,
    output bus_req_t            bus_req,
    output logic                active
);

    ctrl_state_t state;
    word_t       pc;
    word_t       ir;
    word_t       pc_plus4;
    word_t       branch_target;
    word_t       jump_target;
    word_t       next_pc;
    logic        taken;
    logic        fixed_shift;
    logic        mem_op;
    logic        halt_next;

    assign instr = ir;

    // Operand select
    assign fixed_shift = !dec.shift_var &&
                         (dec.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA});
    assign alu_a = fixed_shift ? '0 : rs_data;    // Amount then comes only from shamt
    assign alu_b = (dec.src_b == SRC_IMM) ? dec.imm : rt_data;

    // Next PC, no delay slot
    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {dec.imm[29:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], dec.target, 2'b00};
    assign taken         = (dec.is_beq && alu_equal) || (dec.is_bne && !alu_equal);

    always_comb begin
        if (taken)
            next_pc = branch_target;
        else if (dec.is_j)
            next_pc = jump_target;
        else if (dec.is_jr)
            next_pc = rs_data;
        else
            next_pc = pc_plus4;
    end

    assign halt_next = (next_pc == `MIPS_HALT_ADDR);
    assign mem_op    = dec.is_load || dec.is_store;

    // Sequencer and PC
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= `MIPS_RESET_VECTOR;
        end else begin
            case (state)
                FETCH: begin
                    if (!waitrequest)
                        state <= EXEC;
                end
                EXEC: begin
                    if (mem_op) begin
                        state <= MEM;                    // PC moves when the access completes
                    end else begin
                        pc    <= next_pc;
                        state <= halt_next ? HALT : FETCH;
                    end
                end
                MEM: begin
                    if (!waitrequest) begin
                        pc    <= next_pc;
                        state <= halt_next ? HALT : FETCH;
                    end
                end
                default: state <= HALT;                  // Held until reset
            endcase
        end
    end

    // Instruction register, loaded at the completing fetch edge
    always_ff @(posedge clk) begin
        if ((state == FETCH) && !waitrequest)
            ir <= readdata;
    end

    // Writeback, ALU results in EXEC and load data at the MEM completing edge
    always_comb begin
        wr_addr = dec.wr_addr;
        if (state == MEM) begin
            wr_en   = dec.is_load && !waitrequest;
            wr_data = readdata;
        end else begin
            wr_en   = (state == EXEC) && dec.wr_en && !dec.is_load;
            wr_data = alu_result;
        end
    end

    // Avalon request, stable while waitrequest is high
    always_comb begin
        bus_req = '0;
        case (state)
            FETCH: begin
                bus_req.address = pc;
                bus_req.read    = 1'b1;
            end
            MEM: begin
                bus_req.address   = alu_result;    // rs + offset
                bus_req.read      = dec.is_load;
                bus_req.write     = dec.is_store;
                bus_req.writedata = rt_data;
            end
            default: ;
        endcase
    end

    assign active = (state != HALT);

endmodule

`default_nettype wire

/* mips_cpu_bus.sv */
`default_nettype none

`include "mips_macros.svh"

module mips_cpu_bus
    import mips_core_pkg::*;
    import mips_isa_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    output logic       active,
    output word_t      register_v0,
    output word_t      address,
    output logic       write,
    output logic       read,
    input  wire        waitrequest,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  wire word_t readdata
);

    decoded_instr_t dec;
    bus_req_t       bus_req;
    word_t          instr;
    word_t          rs_data;
    word_t          rt_data;
    word_t          alu_a;
    word_t          alu_b;
    word_t          alu_result;
    logic           alu_equal;
    logic           wr_en;
    reg_addr_t      wr_addr;
    word_t          wr_data;

    mips_control u_control (
        .clk         (clk),
        .reset       (reset),
        .dec         (dec),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .alu_result  (alu_result),
        .alu_equal   (alu_equal),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .instr       (instr),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .bus_req     (bus_req),
        .active      (active)
    );

    mips_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    mips_alu u_alu (
        .op     (dec.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .shamt  (dec.shamt),
        .result (alu_result),
        .equal  (alu_equal)
    );

    mips_reg_file u_reg_file (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (dec.rs),
        .rd_addr_b (dec.rt),
        .rd_data_a (rs_data),
        .rd_data_b (rt_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .v0        (register_v0)
    );

    // Avalon pins
    assign address    = bus_req.address;
    assign read       = bus_req.read;
    assign write      = bus_req.write;
    assign writedata  = bus_req.writedata;
    assign byteenable = (bus_req.read || bus_req.write) ? `MIPS_BYTEEN_ALL : 4'b0000;

endmodule

`default_nettype wire

/* tb_mips_checker.sv */
`default_nettype none

module tb_mips_checker
    import mips_isa_pkg::*;
(
    input wire        clk,
    input wire        reset,
    input wire        active,
    input wire        read,
    input wire        write,
    input wire        waitrequest,
    input wire word_t address,
    input wire word_t writedata,
    input wire [3:0]  byteenable,
    input wire word_t register_v0
);

    word_t      exp_addr [$];    // Expected stores, in program order
    word_t      exp_data [$];
    word_t      act_addr [$];    // Stores seen on the bus
    word_t      act_data [$];
    logic [3:0] act_be [$];
    int         test_errors  = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;

    // A write completes at the edge where waitrequest is low
    always @(posedge clk) begin
        if (!reset && write && !waitrequest) begin
            act_addr.push_back(address);
            act_data.push_back(writedata);
            act_be.push_back(byteenable);
        end
    end

    function automatic void clear_test();
        exp_addr.delete();
        exp_data.delete();
        act_addr.delete();
        act_data.delete();
        act_be.delete();
        test_errors = 0;
    endfunction

    function automatic void expect_store(input word_t a, input word_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endfunction

    // Wrong value, one line with both sides
    function automatic void compare(input string name, input string what,
                                    input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("ERROR %s: %s expected %h, actual %h", name, what, expected, actual);
            test_errors++;
        end
    endfunction

    function automatic void note_failure(input string name, input string msg);
        $display("Test %s: %s", name, msg);
        test_errors++;
    endfunction

    // First bus cycle after reset must be the fetch at the reset vector
    task automatic check_first_fetch(input string name, input int limit);
        int   n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < limit && !seen; n++) begin
            @(posedge clk);
            seen = read;
        end
        if (!seen) begin
            note_failure(name, $sformatf("no instruction read within %0d cycles of reset", limit));
        end else begin
            compare(name, "first read address", 32'hBFC0_0000, address);
            compare(name, "first read byteenable", 32'h0000_000F, {28'd0, byteenable});
            compare(name, "active after reset", 32'd1, {31'd0, active});
        end
    endtask

    // Quiet window after halt, then the store list and v0
    task automatic finish_test(input string name, input word_t exp_v0, input int window);
        int   n;
        logic busy;
        busy = 1'b0;
        for (n = 0; n < window; n++) begin
            @(posedge clk);
            busy = busy | read | write | active;
        end
        if (busy)
            note_failure(name, "bus access or active seen after the CPU should have halted");
        compare(name, "store count", exp_addr.size(), act_addr.size());
        for (n = 0; n < exp_addr.size() && n < act_addr.size(); n++) begin
            compare(name, $sformatf("store %0d address", n), exp_addr[n], act_addr[n]);
            compare(name, $sformatf("store %0d data", n), exp_data[n], act_data[n]);
            compare(name, $sformatf("store %0d byteenable", n),
                    32'h0000_000F, {28'd0, act_be[n]});
        end
        compare(name, "register_v0", exp_v0, register_v0);
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %s: passed, %0d stores", name, act_addr.size());
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, test_errors);
        end
    endtask

    function automatic void report_counts();
        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
    endfunction

    function automatic int failed_count();
        return tests_failed;
    endfunction

endmodule

`default_nettype wire

/* tb_mips_cpu_bus.sv */
`default_nettype none

`include "mips_macros.svh"

module tb_mips_cpu_bus
    import mips_isa_pkg::*;
();

    localparam int    MEM_WORDS = 128;
    localparam word_t PROG_BASE = `MIPS_RESET_VECTOR;
    localparam word_t DATA_BASE = 32'h0000_1000;

    logic       clk;
    logic       reset;
    logic       waitrequest;
    word_t      readdata;
    logic       active;
    logic       read;
    logic       write;
    word_t      address;
    word_t      writedata;
    word_t      register_v0;
    logic [3:0] byteenable;

    word_t  prog_mem [0:MEM_WORDS-1];    // Code at the reset vector
    word_t  data_mem [0:MEM_WORDS-1];    // Data at DATA_BASE
    word_t  ref_addr [$];                // Reference store sequence
    word_t  ref_data [$];
    int     prog_len;
    integer seed;

    mips_cpu_bus mips_cpu_bus_inst (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    tb_mips_checker checker_inst (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .read        (read),
        .write       (write),
        .waitrequest (waitrequest),
        .address     (address),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .register_v0 (register_v0)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Preset data, every bit of the address shows up in the word
    function automatic word_t fill_word(input word_t a);
        return {a[15:0], a[31:16]} ^ 32'h5A5A_A5A5;
    endfunction

    function automatic word_t mem_read(input word_t a);
        if (a >= PROG_BASE && a < PROG_BASE + 4 * MEM_WORDS)
            return prog_mem[(a - PROG_BASE) >> 2];
        if (a >= DATA_BASE && a < DATA_BASE + 4 * MEM_WORDS)
            return data_mem[(a - DATA_BASE) >> 2];
        return 32'hDEAD_0BAD;    // Unmapped
    endfunction

    // Random stalls and read data, set up on the falling edge
    always @(negedge clk) begin
        waitrequest <= (($random(seed) & 3) == 0);
        readdata    <= read ? mem_read(address) : 32'h0;
    end

    always @(posedge clk) begin
        if (!reset && write && !waitrequest &&
            address >= DATA_BASE && address < DATA_BASE + 4 * MEM_WORDS)
            data_mem[(address - DATA_BASE) >> 2] = writedata;
    end

    // Instruction encoders
    function automatic word_t enc_r(input logic [5:0] fn, input int rs, input int rt,
                                    input int rd, input int sh);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input int rs, input int rt,
                                    input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t enc_j(input int idx);
        word_t dest;
        dest = PROG_BASE + 4 * idx;
        return {OP_J, dest[27:2]};
    endfunction

    function automatic void new_program();
        for (int i = 0; i < MEM_WORDS; i++)
            prog_mem[i] = '0;                     // SLL $0 acts as a nop
        prog_len = 0;
    endfunction

    function automatic void emit(input word_t w);
        prog_mem[prog_len] = w;
        prog_len++;
    endfunction

    // ISA-level model, no delay slot, halts on a jump to address 0
    function automatic word_t mips_ref_run(input int max_steps);
        word_t regs [0:31];
        word_t dmem [0:MEM_WORDS-1];
        word_t pc;
        word_t ins;
        word_t a;
        word_t b;
        word_t imm_s;
        word_t ea;
        word_t npc;
        int    steps;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            dmem[i] = fill_word(DATA_BASE + 4 * i);
        ref_addr.delete();
        ref_data.delete();
        pc    = PROG_BASE;
        steps = 0;
        while (pc != `MIPS_HALT_ADDR && steps < max_steps) begin
            ins   = prog_mem[(pc - PROG_BASE) >> 2];
            a     = regs[ins[25:21]];
            b     = regs[ins[20:16]];
            imm_s = {{16{ins[15]}}, ins[15:0]};
            ea    = a + imm_s;                    // Also the ADDIU result
            npc   = pc + 4;
            case (ins[31:26])
                OP_R: begin
                    case (ins[5:0])
                        FN_ADDU: regs[ins[15:11]] = a + b;
                        FN_SUBU: regs[ins[15:11]] = a - b;
                        FN_AND:  regs[ins[15:11]] = a & b;
                        FN_OR:   regs[ins[15:11]] = a | b;
                        FN_XOR:  regs[ins[15:11]] = a ^ b;
                        FN_SLT:  regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLTU: regs[ins[15:11]] = (a < b) ? 32'd1 : 32'd0;
                        FN_SLL:  regs[ins[15:11]] = b << ins[10:6];
                        FN_SRL:  regs[ins[15:11]] = b >> ins[10:6];
                        FN_SRA:  regs[ins[15:11]] = $signed(b) >>> ins[10:6];
                        FN_SLLV: regs[ins[15:11]] = b << a[4:0];
                        FN_SRLV: regs[ins[15:11]] = b >> a[4:0];
                        FN_SRAV: regs[ins[15:11]] = $signed(b) >>> a[4:0];
                        FN_JR:   npc = a;
                        default: ;
                    endcase
                end
                OP_J:     npc = {npc[31:28], ins[25:0], 2'b00};
                OP_BEQ:   if (a == b) npc = npc + (imm_s << 2);
                OP_BNE:   if (a != b) npc = npc + (imm_s << 2);
                OP_ADDIU: regs[ins[20:16]] = ea;
                OP_SLTI:  regs[ins[20:16]] = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
                OP_SLTIU: regs[ins[20:16]] = (a < imm_s) ? 32'd1 : 32'd0;
                OP_ANDI:  regs[ins[20:16]] = a & {16'b0, ins[15:0]};
                OP_ORI:   regs[ins[20:16]] = a | {16'b0, ins[15:0]};
                OP_XORI:  regs[ins[20:16]] = a ^ {16'b0, ins[15:0]};
                OP_LUI:   regs[ins[20:16]] = {ins[15:0], 16'b0};
                OP_LW:    regs[ins[20:16]] = dmem[(ea - DATA_BASE) >> 2];
                OP_SW: begin
                    ref_addr.push_back(ea);
                    ref_data.push_back(b);
                    dmem[(ea - DATA_BASE) >> 2] = b;
                end
                default: ;
            endcase
            regs[0] = '0;                         // $zero drops any write
            pc = npc;
            steps++;
        end
        return regs[`MIPS_V0_INDEX];
    endfunction

    // Every kept R-type op, two operand sets, each result stored
    function automatic void build_reg_alu();
        logic [5:0] fns [0:12];
        int         p;
        int         k;
        int         sh;
        fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU,
                FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
        new_program();
        emit(enc_i(OP_ADDIU, 0, 8, 32'h1000));
        emit(enc_i(OP_ADDIU, 0, 9, -7));
        emit(enc_i(OP_ADDIU, 0, 10, 32'h0123));
        emit(enc_i(OP_ADDIU, 0, 11, 35));         // Low 5 bits give 3
        for (p = 0; p < 2; p++) begin
            for (k = 0; k < 13; k++) begin
                sh = (k >= 7 && k <= 9) ? 4 + 9 * p : 0;    // Fixed shifts only
                emit(enc_r(fns[k], (p == 0) ? 9 : 11, (p == 0) ? 10 : 9, 12, sh));
                emit(enc_i(OP_SW, 8, 12, (p * 13 + k) * 4));
            end
        end
        emit(enc_r(FN_ADDU, 12, 10, 2, 0));
        emit(enc_r(FN_JR, 0, 0, 0, 0));
    endfunction

    function automatic void build_imm_zero();
        new_program();
        emit(enc_i(OP_ADDIU, 0, 8, 32'h1000));
        emit(enc_i(OP_ADDIU, 0, 9, -1));
        emit(enc_i(OP_ADDIU, 9, 10, -32768));
        emit(enc_i(OP_ANDI, 9, 11, 32'h8F0F));    // Zero extended
        emit(enc_i(OP_ORI, 10, 12, 32'hF00D));
        emit(enc_i(OP_XORI, 9, 13, 32'hFFFF));
        emit(enc_i(OP_LUI, 0, 14, 32'h8001));
        emit(enc_i(OP_SLTI, 9, 15, 0));
        emit(enc_i(OP_SLTIU, 10, 16, -1));        // Huge unsigned bound
        emit(enc_i(OP_SLTIU, 9, 17, 5));
        emit(enc_i(OP_ADDIU, 0, 0, 77));          // Both writes to $0 are lost
        emit(enc_r(FN_OR, 9, 9, 0, 0));
        for (int r = 10; r <= 17; r++)
            emit(enc_i(OP_SW, 8, r, (r - 10) * 4));
        emit(enc_i(OP_SW, 8, 0, 32));
        emit(enc_i(OP_ORI, 14, 2, 32'h2345));
        emit(enc_r(FN_JR, 0, 0, 0, 0));
    endfunction

    function automatic void build_load_store();
        new_program();
        emit(enc_i(OP_ADDIU, 0, 8, 32'h1020));
        emit(enc_i(OP_LW, 8, 9, -8));             // Preset word
        emit(enc_i(OP_ADDIU, 9, 9, 1));
        emit(enc_i(OP_SW, 8, 9, 12));
        emit(enc_i(OP_LW, 8, 10, 12));            // Round trip
        emit(enc_i(OP_SW, 8, 10, -16));
        emit(enc_i(OP_LW, 8, 11, 40));
        emit(enc_i(OP_LW, 8, 12, -32));
        emit(enc_r(FN_XOR, 11, 12, 13, 0));
        emit(enc_i(OP_SW, 8, 13, 0));
        emit(enc_i(OP_SW, 8, 8, 4));
        emit(enc_i(OP_LW, 8, 2, 0));
        emit(enc_r(FN_JR, 0, 0, 0, 0));
    endfunction

    // Word index of each instruction in the trailing comments
    function automatic void build_control();
        new_program();
        emit(enc_i(OP_ADDIU, 0, 8, 32'h1000));    // 0
        emit(enc_i(OP_ADDIU, 0, 9, 5));
        emit(enc_i(OP_ADDIU, 0, 10, 5));
        emit(enc_i(OP_BEQ, 9, 10, 1));            // 3 taken to 5
        emit(enc_i(OP_SW, 8, 0, 0));
        emit(enc_i(OP_SW, 8, 9, 4));              // 5
        emit(enc_i(OP_BNE, 9, 10, 1));            // Not taken
        emit(enc_i(OP_SW, 8, 10, 8));
        emit(enc_i(OP_ADDIU, 10, 10, 1));
        emit(enc_i(OP_BNE, 9, 10, 1));            // 9 taken to 11
        emit(enc_i(OP_SW, 8, 9, 12));
        emit(enc_i(OP_BEQ, 9, 10, 1));            // 11 not taken
        emit(enc_i(OP_SW, 8, 10, 16));
        emit(enc_j(15));                          // 13
        emit(enc_i(OP_SW, 8, 0, 20));
        emit(enc_i(OP_ADDIU, 0, 11, 3));          // 15
        emit(enc_i(OP_ADDIU, 11, 11, -1));        // 16 loop top
        emit(enc_i(OP_SW, 8, 11, 24));
        emit(enc_i(OP_BNE, 11, 0, -3));           // Back to 16
        emit(enc_i(OP_ADDIU, 9, 2, 100));
        emit(enc_r(FN_JR, 0, 0, 0, 0));
    endfunction

    function automatic void build_halt();
        new_program();
        emit(enc_i(OP_ORI, 0, 2, 32'hBEEF));
        emit(enc_i(OP_ADDIU, 0, 8, 32'h1000));
        emit(enc_r(FN_JR, 0, 0, 0, 0));
        emit(enc_i(OP_SW, 8, 2, 0));              // Never reached
        emit(enc_i(OP_ADDIU, 0, 2, 1));
    endfunction

    task automatic run_test(input string name);
        word_t exp_v0;
        int    cycles;
        exp_v0 = mips_ref_run(2000);
        checker_inst.clear_test();
        foreach (ref_addr[i])
            checker_inst.expect_store(ref_addr[i], ref_data[i]);
        for (int i = 0; i < MEM_WORDS; i++)
            data_mem[i] = fill_word(DATA_BASE + 4 * i);
        @(negedge clk);
        reset = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        checker_inst.check_first_fetch(name, 20);
        cycles = 0;
        while (active && cycles < 4000) begin
            @(negedge clk);
            cycles++;
        end
        if (active)
            checker_inst.note_failure(name, "CPU did not halt within 4000 cycles");
        checker_inst.finish_test(name, exp_v0, 20);
    endtask

    initial begin
        seed        = 32'haaf2;
        reset       = 1'b1;
        waitrequest = 1'b0;
        readdata    = '0;
        build_reg_alu();
        run_test("reg_alu");
        build_imm_zero();
        run_test("imm_zero");
        build_load_store();
        run_test("load_store");
        build_control();
        run_test("control_flow");
        build_halt();
        run_test("halt");
        checker_inst.report_counts();
        if (checker_inst.failed_count() == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
mips_core_pkg.sv
mips_isa_pkg.sv
mips_decoder.sv
mips_alu.sv
mips_reg_file.sv
mips_control.sv
mips_cpu_bus.sv
tb_mips_checker.sv
tb_mips_cpu_bus.sv
